// ==== Bender.yml ====
package:
  name: roce_core

sources:
  - src/roce_pkg.sv
  - src/roce_conn_manager.sv
  - src/roce_req_fifo.sv
  - src/roce_write_gen.sv
  - src/roce_core.sv
  - target: test
    files:
      - dv/roce_core_asserts.sv
      - dv/roce_core_tb.sv

// ==== dv/roce_core_asserts.sv ====
`timescale 1ns/1ps

module roce_core_asserts (
  input logic clk,
  input logic rst,
  input logic push,
  input logic pop,
  input logic full,
  input logic empty
);

  import roce_pkg::*;

  // Manager holds the completing beat back while the queue is full
  assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("Request pushed while the FIFO was full");

  assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("Request popped while the FIFO was empty");

  assert property (@(posedge clk) disable iff (rst) !(empty && full))
    else $error("FIFO flags empty and full both set");

endmodule

bind roce_req_fifo roce_core_asserts u_asserts (
  .clk   (clk),
  .rst   (rst),
  .push  (push),
  .pop   (pop),
  .full  (full),
  .empty (empty)
);

// ==== dv/roce_core_tb.sv ====
`timescale 1ns/1ps

module roce_core_tb;

  import roce_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_RAND = 40;
  // Directed frames 1 + 4 + 5 + (REQ_DEPTH + 2) plus the random ones
  localparam int N_FRAMES = 10 + REQ_DEPTH_DEFAULT + 2 + N_RAND;
  // Requests carry at most 64 bytes and thus 8 payload beats
  localparam int TIMEOUT_CYCLES = N_FRAMES * 40 + N_FRAMES * 8 * 4;

  logic  clk;
  logic  rst;
  logic  s_valid;
  data_t s_data;
  logic  s_last;
  port_t s_dest_port;
  logic  s_ready;
  logic  m_valid;
  data_t m_data;
  logic  m_last;
  logic  m_ready;

  data_t       tx_q[$];
  data_t       exp_data[$];
  logic        exp_last[$];
  logic [31:0] stim_seed = 32'd53623;
  logic [31:0] ready_seed = 32'd53623;
  int          ready_mode = 0;
  logic        saw_stall = 1'b0;
  int          data_errors = 0;
  int          last_errors = 0;
  int          proto_errors = 0;
  int          i;
  int          j;
  len_t        lens[5] = '{32'd0, 32'd1, 32'd7, 32'd9, 32'd63};

  // Request monitor state
  int     mon_beat;
  vaddr_t mon_vaddr;
  rkey_t  mon_rkey;
  len_t   mon_len;

  // Output compare state
  logic  stalled;
  data_t held_data;
  logic  held_last;
  data_t exp_d;
  logic  exp_l;

  roce_core #(
    .LISTEN_PORT (LISTEN_PORT_DEFAULT),
    .REQ_DEPTH   (REQ_DEPTH_DEFAULT)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_last      (s_last),
    .s_dest_port (s_dest_port),
    .s_ready     (s_ready),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .m_last      (m_last),
    .m_ready     (m_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  // Reference model of the expected beats of one WRITE-only frame
  function automatic void build_frame(vaddr_t va, rkey_t rk, len_t ln, qpn_t qp, psn_t ps);
    longint n_pay;
    longint k;
    n_pay = (longint'(ln) + 64'd7) / 8;
    exp_data.push_back({OPCODE_WRITE_ONLY, qp, ps, 8'h00});
    exp_last.push_back(1'b0);
    exp_data.push_back({va, 16'h0000});
    exp_last.push_back(1'b0);
    exp_data.push_back({rk, ln});
    exp_last.push_back(n_pay == 0);
    for (k = 0; k < n_pay; k++) begin
      exp_data.push_back(data_t'(k));
      exp_last.push_back(k == n_pay - 1);
    end
  endfunction

  // Sends the beats in tx_q starting on a falling edge
  task automatic drive_frame(input port_t port, input bit gaps);
    logic [31:0] r;
    int          n;
    s_dest_port = port;
    for (n = 0; n < tx_q.size(); n++) begin
      if (gaps) begin
        r = rand_word();
        repeat (r[29:28]) begin
          s_valid = 1'b0;
          @(negedge clk);
        end
      end
      s_valid = 1'b1;
      s_data  = tx_q[n];
      s_last  = (n == tx_q.size() - 1);
      @(posedge clk);
      while (!s_ready) @(posedge clk);
      @(negedge clk);
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic send_request(input vaddr_t va, rkey_t rk, len_t ln, qpn_t qp, psn_t ps,
                              input int extra, input bit gaps);
    int n;
    tx_q.delete();
    // Junk in the ignored low bits
    tx_q.push_back({va, 16'hBEEF});
    tx_q.push_back({rk, ln});
    tx_q.push_back({qp, ps, 16'hA5A5});
    for (n = 0; n < extra; n++) begin
      tx_q.push_back(64'hDEAD_0000_0000_0000 | data_t'(n));
    end
    drive_frame(LISTEN_PORT_DEFAULT, gaps);
  endtask

  task automatic send_random_request();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    r0 = rand_word();
    r1 = rand_word();
    r2 = rand_word();
    r3 = rand_word();
    r4 = rand_word();
    send_request({r0[31:16], r1}, r2, r3 % 32'd65, r4[31:8], {r0[7:0], r3[31:16]}, 0, 1'b1);
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    assert (!m_valid) else begin
      $display("Output still active after every expected beat arrived");
      proto_errors++;
    end
  endtask

  // Output ready pattern
  initial begin
    m_ready = 1'b1;
    forever begin
      @(negedge clk);
      ready_seed = lcg_step(ready_seed);
      case (ready_mode)
        0:       m_ready = 1'b1;
        1:       m_ready = 1'b0;
        default: m_ready = ready_seed[30];
      endcase
    end
  end

  // Records each request when its third beat is accepted
  always @(posedge clk) begin
    if (rst) begin
      mon_beat = 0;
    end else begin
      if (s_valid && !s_ready) begin
        saw_stall = 1'b1;
        assert (mon_beat == 2 && s_dest_port == LISTEN_PORT_DEFAULT) else begin
          $display("s_ready dropped on beat %0d, not on a third request beat", mon_beat);
          proto_errors++;
        end
      end
      if (s_valid && s_ready) begin
        if (s_dest_port == LISTEN_PORT_DEFAULT) begin
          case (mon_beat)
            0: mon_vaddr = s_data[63:16];
            1: begin
              mon_rkey = s_data[63:32];
              mon_len  = s_data[31:0];
            end
            2: build_frame(mon_vaddr, mon_rkey, mon_len, s_data[63:40], s_data[39:16]);
            default: ;
          endcase
        end
        mon_beat = s_last ? 0 : ((mon_beat < 3) ? mon_beat + 1 : 3);
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        assert (m_valid && m_data === held_data && m_last === held_last) else begin
          $display("FAILED %0t: output beat changed while stalled", $time);
          proto_errors++;
        end
      end
      if (m_valid && m_ready) begin
        assert (exp_data.size() != 0) else begin
          $display("Output beat %h arrived with no frame expected", m_data);
          proto_errors++;
        end
        if (exp_data.size() != 0) begin
          exp_d = exp_data.pop_front();
          exp_l = exp_last.pop_front();
          assert (m_data === exp_d) else begin
            $display("FAILED %0t: m_data %h, expected %h", $time, m_data, exp_d);
            data_errors++;
          end
          assert (m_last === exp_l) else begin
            $display("FAILED %0t: m_last %b, expected %b", $time, m_last, exp_l);
            last_errors++;
          end
        end
      end
      stalled   = m_valid && !m_ready;
      held_data = m_data;
      held_last = m_last;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, frames did not complete", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    s_valid     = 1'b0;
    s_data      = '0;
    s_last      = 1'b0;
    s_dest_port = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle after reset, then one request
    assert (!m_valid && s_ready) else begin
      $display("FAILED %0t: after reset m_valid=%b s_ready=%b", $time, m_valid, s_ready);
      proto_errors++;
    end
    send_request(48'h1234_5678_9ABC, 32'h0BAD_F00D, 32'd20, 24'h00_0042, 24'h10_0000, 0, 1'b0);
    wait_drain();

    // Other port, short frames, then extra beats
    tx_q = '{64'h1111_2222_3333_4444, 64'h5555_6666_0000_0010, 64'h7777_7788_8888_0000};
    drive_frame(16'h1234, 1'b0);
    tx_q = '{64'h0123_4567_89AB_0000};
    drive_frame(LISTEN_PORT_DEFAULT, 1'b0);
    tx_q = '{64'h0123_4567_89AB_0000, 64'hFEED_0000_0000_0008};
    drive_frame(LISTEN_PORT_DEFAULT, 1'b0);
    repeat (8) @(negedge clk);
    assert (!m_valid) else begin
      $display("Discarded frames produced output");
      proto_errors++;
    end
    send_request(48'hAAAA_BBBB_CCCC, 32'h0000_0077, 32'd16, 24'h00_0007, 24'h00_0100, 3, 1'b0);
    wait_drain();

    // Zero and unaligned lengths
    for (i = 0; i < 5; i++) begin
      send_request(48'h0A0B_0C0D_0E0F, 32'hCAFE_0001, lens[i], 24'h000100 + 24'(i),
                   24'h000200 + 24'(i), 0, 1'b0);
    end
    wait_drain();

    // Fill the queue while the output is stalled
    saw_stall  = 1'b0;
    ready_mode = 1;
    @(negedge clk);
    for (i = 0; i < REQ_DEPTH_DEFAULT + 1; i++) begin
      send_request(48'h0000_1000_0000 + i, 32'h5000 + i, 32'(i * 8 + 3), 24'(i), 24'(i + 64),
                   0, 1'b0);
    end
    fork
      send_request(48'h0000_2000_0000, 32'h6000, 32'd11, 24'h0000FF, 24'h0000EE, 0, 1'b0);
      begin
        for (j = 0; j < 20 && !saw_stall; j++) @(negedge clk);
        assert (saw_stall) else begin
          $display("s_ready never dropped with the request queue full");
          proto_errors++;
        end
        ready_mode = 0;
      end
    join
    wait_drain();

    // Random requests under random stalls
    ready_mode = 2;
    for (i = 0; i < N_RAND; i++) begin
      send_random_request();
    end
    wait_drain();

    $display("Errors: %0d data, %0d last, %0d protocol", data_errors, last_errors,
             proto_errors);
    if (data_errors + last_errors + proto_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== src/roce_conn_manager.sv ====
`timescale 1ns/1ps

module roce_conn_manager #(
  parameter roce_pkg::port_t LISTEN_PORT = roce_pkg::LISTEN_PORT_DEFAULT
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             s_valid,
  input  roce_pkg::data_t  s_data,
  input  logic             s_last,
  input  roce_pkg::port_t  s_dest_port,
  output logic             s_ready,
  input  logic             full,
  output logic             push,
  output roce_pkg::req_t   push_data
);

  import roce_pkg::*;

  req_beat_t beat_q;
  vaddr_t    vaddr_q;
  rkey_t     rkey_q;
  len_t      len_q;

  logic port_match;
  logic at_qpn;
  logic accept;

  assign port_match = (s_dest_port == LISTEN_PORT);
  assign at_qpn     = (beat_q == QPN) && port_match;

  // Stall only the completing beat while the queue has no room
  assign s_ready = !(at_qpn && full);
  assign accept  = s_valid && s_ready;

  assign push = s_valid && at_qpn && !full;

  // Third beat supplies qpn and psn directly
  assign push_data = {vaddr_q, rkey_q, len_q, s_data[63:40], s_data[39:16]};

  // Position within the frame restarts after every last beat
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= ADDR;
    end else if (accept) begin
      if (s_last) begin
        beat_q <= ADDR;
      end else begin
        case (beat_q)
          ADDR:    beat_q <= KEYLEN;
          KEYLEN:  beat_q <= QPN;
          QPN:     beat_q <= SKIP;
          default: beat_q <= SKIP;
        endcase
      end
    end
  end

  // Field capture for the first two beats
  always_ff @(posedge clk) begin
    if (accept) begin
      if (beat_q == ADDR) begin
        // Low 16 bits of the address beat carry nothing
        vaddr_q <= s_data[63:16];
      end
      if (beat_q == KEYLEN) begin
        rkey_q <= s_data[63:32];
        len_q  <= s_data[31:0];
      end
    end
  end

endmodule

// ==== src/roce_core.sv ====
`timescale 1ns/1ps

module roce_core #(
  parameter roce_pkg::port_t LISTEN_PORT = roce_pkg::LISTEN_PORT_DEFAULT,
  parameter int              REQ_DEPTH   = roce_pkg::REQ_DEPTH_DEFAULT
) (
  input  logic             clk,
  input  logic             rst,

  // Request datagrams from the UDP side
  input  logic             s_valid,
  input  roce_pkg::data_t  s_data,
  input  logic             s_last,
  input  roce_pkg::port_t  s_dest_port,
  output logic             s_ready,

  // Outgoing RDMA WRITE frames
  output logic             m_valid,
  output roce_pkg::data_t  m_data,
  output logic             m_last,
  input  logic             m_ready
);

  import roce_pkg::*;

  logic push;
  logic full;
  logic pop;
  logic empty;
  req_t push_data;
  req_t pop_data;

  roce_conn_manager #(
    .LISTEN_PORT (LISTEN_PORT)
  ) u_conn_manager (
    .clk         (clk),
    .rst         (rst),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_last      (s_last),
    .s_dest_port (s_dest_port),
    .s_ready     (s_ready),
    .full        (full),
    .push        (push),
    .push_data   (push_data)
  );

  roce_req_fifo #(
    .DEPTH (REQ_DEPTH),
    .WIDTH (REQ_W)
  ) u_req_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty)
  );

  roce_write_gen u_write_gen (
    .clk      (clk),
    .rst      (rst),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .m_valid  (m_valid),
    .m_data   (m_data),
    .m_last   (m_last),
    .m_ready  (m_ready)
  );

endmodule

// ==== src/roce_pkg.sv ====
package roce_pkg;

  // Stream and field widths
  typedef logic [63:0] data_t;
  typedef logic [15:0] port_t;
  typedef logic [47:0] vaddr_t;
  typedef logic [31:0] rkey_t;
  typedef logic [31:0] len_t;
  typedef logic [23:0] qpn_t;
  typedef logic [23:0] psn_t;

  // Packed request with vaddr in the top bits down to psn at the bottom
  localparam int REQ_W = $bits(vaddr_t) + $bits(rkey_t) + $bits(len_t)
                       + $bits(qpn_t) + $bits(psn_t);

  typedef logic [REQ_W-1:0] req_t;

  // RDMA WRITE-only opcode for the BTH
  localparam logic [7:0] OPCODE_WRITE_ONLY = 8'h0A;

  localparam port_t LISTEN_PORT_DEFAULT = 16'h4321;
  localparam int REQ_DEPTH_DEFAULT = 4;

  // Beat position within an incoming request datagram
  typedef enum logic [1:0] {
    ADDR,
    KEYLEN,
    QPN,
    SKIP
  } req_beat_t;

  // Write frame generator states
  typedef enum logic [2:0] {
    IDLE,
    BTH,
    RETH_ADDR,
    RETH_KEYLEN,
    PAYLOAD
  } gen_state_t;

endpackage

// ==== src/roce_req_fifo.sv ====
`timescale 1ns/1ps

module roce_req_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 160
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;

  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  // Show-ahead head entry
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      count <= count + CW'(push) - CW'(pop);
    end
  end

endmodule

// ==== src/roce_write_gen.sv ====
`timescale 1ns/1ps

module roce_write_gen (
  input  logic             clk,
  input  logic             rst,
  input  logic             empty,
  input  roce_pkg::req_t   pop_data,
  output logic             pop,
  output logic             m_valid,
  output roce_pkg::data_t  m_data,
  output logic             m_last,
  input  logic             m_ready
);

  import roce_pkg::*;

  gen_state_t state_q;
  len_t       beat_cnt;

  vaddr_t vaddr_q;
  rkey_t  rkey_q;
  len_t   len_q;
  qpn_t   qpn_q;
  psn_t   psn_q;

  logic [32:0] len_round;
  len_t        n_beats;
  logic        payload_end;
  logic        accept;

  // Payload beats are len rounded up to whole 8 byte words
  assign len_round   = {1'b0, len_q} + 33'd7;
  assign n_beats     = {2'b00, len_round[32:3]};
  assign payload_end = (beat_cnt == n_beats - len_t'(1));

  assign pop     = (state_q == IDLE) && !empty;
  assign m_valid = (state_q != IDLE);
  assign accept  = m_valid && m_ready;

  // Zero length stops after the RETH
  assign m_last = ((state_q == RETH_KEYLEN) && (len_q == '0))
               || ((state_q == PAYLOAD) && payload_end);

  always_comb begin
    case (state_q)
      BTH:         m_data = {OPCODE_WRITE_ONLY, qpn_q, psn_q, 8'h00};
      RETH_ADDR:   m_data = {vaddr_q, 16'h0000};
      RETH_KEYLEN: m_data = {rkey_q, len_q};
      PAYLOAD:     m_data = {32'h0000_0000, beat_cnt};
      default:     m_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      {vaddr_q, rkey_q, len_q, qpn_q, psn_q} <= pop_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (pop) begin
            state_q <= BTH;
          end
        end
        BTH: if (accept) state_q <= RETH_ADDR;
        RETH_ADDR: if (accept) state_q <= RETH_KEYLEN;
        RETH_KEYLEN: begin
          if (accept) begin
            state_q  <= (len_q == '0) ? IDLE : PAYLOAD;
            beat_cnt <= '0;
          end
        end
        PAYLOAD: begin
          if (accept) begin
            if (payload_end) begin
              state_q <= IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== verilog.f ====
src/roce_pkg.sv
src/roce_conn_manager.sv
src/roce_req_fifo.sv
src/roce_write_gen.sv
src/roce_core.sv
dv/roce_core_asserts.sv
dv/roce_core_tb.sv
